// File: verilog/regfile_pkg.sv
package regfile_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Register file geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int NUM_REGS     = 8;
    localparam int NUM_GPR_SECS = 24;  // Section index is register * 3 + section
    localparam int NUM_SECS     = 32;  // MMX registers occupy 24 to 31

    localparam int SEC_E = 2;  // Bits 31:16
    localparam int SEC_H = 1;  // Bits 15:8
    localparam int SEC_L = 0;  // Bits 7:0

    localparam int TAG_W = 7;

    typedef logic [2:0]          reg_addr_t;
    typedef logic [TAG_W-1:0]    tag_t;
    typedef logic [63:0]         data_t;
    typedef logic [NUM_SECS-1:0] sec_mask_t;

    typedef enum logic {
        file_gpr,
        file_mmx
    } reg_file_e;

    // The size is ignored for the MMX file, which is always 64 bits wide
    typedef enum logic [1:0] {
        size8,
        size16,
        size32,
        size64
    } op_size_e;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Requests and results
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    typedef struct packed {
        logic      valid;
        reg_file_e file;
        op_size_e  size;
        reg_addr_t addr;
        data_t     data;
    } wr_req_t;

    typedef struct packed {
        logic      valid;
        reg_file_e file;
        op_size_e  size;
        reg_addr_t addr;
        tag_t      tag;
    } rsv_req_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } bcast_t;

    typedef struct packed {
        reg_file_e file;
        op_size_e  size;
        reg_addr_t addr;
    } rd_req_t;

    // Pending bits are indexed by SEC_E, SEC_H and SEC_L
    typedef struct packed {
        data_t      data;
        logic [2:0] pending;
        tag_t       tag_e;
        tag_t       tag_h;
        tag_t       tag_l;
    } rd_result_t;

endpackage

// File: verilog/access_decoder.sv
`timescale 1ns/10ps

module access_decoder (
    input  regfile_pkg::wr_req_t   req,
    output regfile_pkg::sec_mask_t mask,
    output logic [15:0]            lane_e,
    output logic [7:0]             lane_h,
    output logic [7:0]             lane_l,
    output regfile_pkg::data_t     lane_mmx
);

    logic byte_high;  // 8-bit access to the high byte of registers 0 to 3

    assign byte_high = (req.file == regfile_pkg::file_gpr) &&
                       (req.size == regfile_pkg::size8) && req.addr[2];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Section mask
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        int base;
        int byte_base;
        base      = int'(req.addr) * 3;
        byte_base = int'(req.addr[1:0]) * 3;
        mask      = '0;
        if (req.valid) begin
            if (req.file == regfile_pkg::file_mmx) begin
                mask[regfile_pkg::NUM_GPR_SECS + int'(req.addr)] = 1'b1;
            end else begin
                case (req.size)
                    regfile_pkg::size8: begin
                        if (byte_high) begin
                            mask[byte_base + regfile_pkg::SEC_H] = 1'b1;
                        end else begin
                            mask[byte_base + regfile_pkg::SEC_L] = 1'b1;
                        end
                    end
                    regfile_pkg::size16: begin
                        mask[base + regfile_pkg::SEC_H] = 1'b1;
                        mask[base + regfile_pkg::SEC_L] = 1'b1;
                    end
                    regfile_pkg::size32: begin
                        mask[base + regfile_pkg::SEC_E] = 1'b1;
                        mask[base + regfile_pkg::SEC_H] = 1'b1;
                        mask[base + regfile_pkg::SEC_L] = 1'b1;
                    end
                    default: begin
                        mask = '0;  // No 64-bit general register exists
                    end
                endcase
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Data lanes, aligned to their sections
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    assign lane_e   = req.data[31:16];
    assign lane_h   = byte_high ? req.data[7:0] : req.data[15:8];  // AH..BH take the low byte
    assign lane_l   = req.data[7:0];
    assign lane_mmx = req.data;

endmodule

// File: verilog/reg_storage.sv
`timescale 1ns/10ps

module reg_storage (
    input  logic                                                clk,
    input  logic                                                reset,
    input  regfile_pkg::sec_mask_t                              mask0,
    input  regfile_pkg::sec_mask_t                              mask1,
    input  logic [15:0]                                         lane_e0,
    input  logic [7:0]                                          lane_h0,
    input  logic [7:0]                                          lane_l0,
    input  regfile_pkg::data_t                                  lane_mmx0,
    input  logic [15:0]                                         lane_e1,
    input  logic [7:0]                                          lane_h1,
    input  logic [7:0]                                          lane_l1,
    input  regfile_pkg::data_t                                  lane_mmx1,
    output logic [regfile_pkg::NUM_REGS-1:0][31:0]              gpr_q,
    output regfile_pkg::data_t [regfile_pkg::NUM_REGS-1:0]      mmx_q
);

    // Port 1 wins whenever both ports write the same section
    always_ff @(posedge clk) begin
        if (reset) begin
            gpr_q <= '0;
            mmx_q <= '0;
        end else begin
            for (int r = 0; r < regfile_pkg::NUM_REGS; r++) begin
                if (mask1[r*3 + regfile_pkg::SEC_E]) begin
                    gpr_q[r][31:16] <= lane_e1;
                end else if (mask0[r*3 + regfile_pkg::SEC_E]) begin
                    gpr_q[r][31:16] <= lane_e0;
                end

                if (mask1[r*3 + regfile_pkg::SEC_H]) begin
                    gpr_q[r][15:8] <= lane_h1;
                end else if (mask0[r*3 + regfile_pkg::SEC_H]) begin
                    gpr_q[r][15:8] <= lane_h0;
                end

                if (mask1[r*3 + regfile_pkg::SEC_L]) begin
                    gpr_q[r][7:0] <= lane_l1;
                end else if (mask0[r*3 + regfile_pkg::SEC_L]) begin
                    gpr_q[r][7:0] <= lane_l0;
                end

                // MMX registers are a single section each
                if (mask1[regfile_pkg::NUM_GPR_SECS + r]) begin
                    mmx_q[r] <= lane_mmx1;
                end else if (mask0[regfile_pkg::NUM_GPR_SECS + r]) begin
                    mmx_q[r] <= lane_mmx0;
                end
            end
        end
    end

endmodule

// File: verilog/tag_tracker.sv
`timescale 1ns/10ps

module tag_tracker (
    input  logic                                               clk,
    input  logic                                               reset,
    input  regfile_pkg::sec_mask_t                             rsv_mask,
    input  regfile_pkg::tag_t                                  rsv_tag,
    input  regfile_pkg::bcast_t                                bcast,
    output regfile_pkg::sec_mask_t                             pending,
    output regfile_pkg::tag_t [regfile_pkg::NUM_SECS-1:0]      tags
);

    regfile_pkg::sec_mask_t bcast_hit;  // Sections whose stored tag matches the broadcast

    always_comb begin
        for (int s = 0; s < regfile_pkg::NUM_SECS; s++) begin
            bcast_hit[s] = bcast.valid && (tags[s] == bcast.tag);
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Scoreboard update
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
            tags    <= '0;
        end else begin
            for (int s = 0; s < regfile_pkg::NUM_SECS; s++) begin
                if (rsv_mask[s]) begin
                    // A new reservation overrides a result arriving in the same cycle
                    pending[s] <= 1'b1;
                    tags[s]    <= rsv_tag;
                end else if (bcast_hit[s]) begin
                    pending[s] <= 1'b0;  // Tag stays as it was
                end
            end
        end
    end

endmodule

// File: verilog/read_port.sv
`timescale 1ns/10ps

module read_port (
    input  regfile_pkg::rd_req_t                               req,
    input  logic [regfile_pkg::NUM_REGS-1:0][31:0]             gpr_q,
    input  regfile_pkg::data_t [regfile_pkg::NUM_REGS-1:0]     mmx_q,
    input  regfile_pkg::sec_mask_t                             pending,
    input  regfile_pkg::tag_t [regfile_pkg::NUM_SECS-1:0]      tags,
    output regfile_pkg::rd_result_t                            result
);

    logic [31:0] gpr_word;   // Register selected by the full address
    logic [31:0] byte_word;  // Register selected by an 8-bit address

    assign gpr_word  = gpr_q[req.addr];
    assign byte_word = gpr_q[req.addr[1:0]];

    always_comb begin
        int base;
        int sec;
        base   = int'(req.addr) * 3;
        sec    = req.addr[2] ? regfile_pkg::SEC_H : regfile_pkg::SEC_L;
        result = '0;
        if (req.file == regfile_pkg::file_mmx) begin
            base                                = regfile_pkg::NUM_GPR_SECS + int'(req.addr);
            result.data                         = mmx_q[req.addr];
            result.pending[regfile_pkg::SEC_L]  = pending[base];
            result.tag_l                        = tags[base];
        end else begin
            case (req.size)
                regfile_pkg::size8: begin
                    // The byte lands in bits 7:0 and its status in the L slot
                    base                               = int'(req.addr[1:0]) * 3;
                    result.data[7:0]                   = req.addr[2] ? byte_word[15:8]
                                                                     : byte_word[7:0];
                    result.pending[regfile_pkg::SEC_L] = pending[base + sec];
                    result.tag_l                       = tags[base + sec];
                end
                regfile_pkg::size16: begin
                    result.data[15:0]                  = gpr_word[15:0];
                    result.pending[regfile_pkg::SEC_H] = pending[base + regfile_pkg::SEC_H];
                    result.pending[regfile_pkg::SEC_L] = pending[base + regfile_pkg::SEC_L];
                    result.tag_h                       = tags[base + regfile_pkg::SEC_H];
                    result.tag_l                       = tags[base + regfile_pkg::SEC_L];
                end
                regfile_pkg::size32: begin
                    result.data[31:0]                  = gpr_word;
                    result.pending[regfile_pkg::SEC_E] = pending[base + regfile_pkg::SEC_E];
                    result.pending[regfile_pkg::SEC_H] = pending[base + regfile_pkg::SEC_H];
                    result.pending[regfile_pkg::SEC_L] = pending[base + regfile_pkg::SEC_L];
                    result.tag_e                       = tags[base + regfile_pkg::SEC_E];
                    result.tag_h                       = tags[base + regfile_pkg::SEC_H];
                    result.tag_l                       = tags[base + regfile_pkg::SEC_L];
                end
                default: begin
                    result = '0;  // A 64-bit general read covers no section
                end
            endcase
        end
    end

endmodule

// File: verilog/regfile_top.sv
`timescale 1ns/10ps

module regfile_top (
    input  logic                    clk,
    input  logic                    reset,
    input  regfile_pkg::wr_req_t    wr0,
    input  regfile_pkg::wr_req_t    wr1,
    input  regfile_pkg::rsv_req_t   rsv,
    input  regfile_pkg::bcast_t     bcast,
    input  regfile_pkg::rd_req_t    rd0,
    input  regfile_pkg::rd_req_t    rd1,
    output regfile_pkg::rd_result_t rd0_result,
    output regfile_pkg::rd_result_t rd1_result
);

    regfile_pkg::sec_mask_t wr0_mask;
    regfile_pkg::sec_mask_t wr1_mask;
    regfile_pkg::sec_mask_t rsv_mask;
    logic [15:0]            wr0_lane_e;
    logic [15:0]            wr1_lane_e;
    logic [7:0]             wr0_lane_h;
    logic [7:0]             wr1_lane_h;
    logic [7:0]             wr0_lane_l;
    logic [7:0]             wr1_lane_l;
    regfile_pkg::data_t     wr0_lane_mmx;
    regfile_pkg::data_t     wr1_lane_mmx;
    regfile_pkg::wr_req_t   rsv_as_wr;

    logic [regfile_pkg::NUM_REGS-1:0][31:0]             gpr_q;
    regfile_pkg::data_t [regfile_pkg::NUM_REGS-1:0]     mmx_q;
    regfile_pkg::sec_mask_t                             pending;
    regfile_pkg::tag_t [regfile_pkg::NUM_SECS-1:0]      tags;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request decode
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    access_decoder u_wr0_dec (.req(wr0), .mask(wr0_mask), .lane_e(wr0_lane_e),
                              .lane_h(wr0_lane_h), .lane_l(wr0_lane_l),
                              .lane_mmx(wr0_lane_mmx));

    access_decoder u_wr1_dec (.req(wr1), .mask(wr1_mask), .lane_e(wr1_lane_e),
                              .lane_h(wr1_lane_h), .lane_l(wr1_lane_l),
                              .lane_mmx(wr1_lane_mmx));

    // Reserve only needs the section mask so it carries no data
    assign rsv_as_wr = '{valid: rsv.valid, file: rsv.file, size: rsv.size,
                         addr: rsv.addr, data: '0};

    access_decoder u_rsv_dec (.req(rsv_as_wr), .mask(rsv_mask), .lane_e(),
                              .lane_h(), .lane_l(), .lane_mmx());

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // State
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    reg_storage u_storage (.clk(clk), .reset(reset), .mask0(wr0_mask), .mask1(wr1_mask),
                           .lane_e0(wr0_lane_e), .lane_h0(wr0_lane_h),
                           .lane_l0(wr0_lane_l), .lane_mmx0(wr0_lane_mmx),
                           .lane_e1(wr1_lane_e), .lane_h1(wr1_lane_h),
                           .lane_l1(wr1_lane_l), .lane_mmx1(wr1_lane_mmx),
                           .gpr_q(gpr_q), .mmx_q(mmx_q));

    tag_tracker u_tracker (.clk(clk), .reset(reset), .rsv_mask(rsv_mask),
                           .rsv_tag(rsv.tag), .bcast(bcast),
                           .pending(pending), .tags(tags));

    // Reads see the state as of the last edge
    read_port u_rd0_port (.req(rd0), .gpr_q(gpr_q), .mmx_q(mmx_q), .pending(pending),
                          .tags(tags), .result(rd0_result));

    read_port u_rd1_port (.req(rd1), .gpr_q(gpr_q), .mmx_q(mmx_q), .pending(pending),
                          .tags(tags), .result(rd1_result));

endmodule

// File: tests/clock_gen.sv
`timescale 1ns/10ps

module clock_gen (
    output logic clk,
    output logic reset
);

    localparam int HALF_PERIOD  = 10;  // 20 ns clock
    localparam int RESET_CYCLES = 4;

    initial begin
        clk = 1'b0;
        forever #(HALF_PERIOD) clk = ~clk;
    end

    // Released 2 ns after an edge, in step with the rest of the stimulus
    initial begin
        reset = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        reset = 1'b0;
    end

endmodule

// File: tests/regfile_tb.sv
`timescale 1ns/10ps

module regfile_tb;

    localparam logic [31:0] SEED          = 32'hd014ea23;
    localparam int          RESET_TIMEOUT = 50;  // Cycles
    localparam int          RANDOM_CYCLES = 300;

    logic                    clk;
    logic                    reset;
    regfile_pkg::wr_req_t    wr0;
    regfile_pkg::wr_req_t    wr1;
    regfile_pkg::rsv_req_t   rsv;
    regfile_pkg::bcast_t     bcast;
    regfile_pkg::rd_req_t    rd0;
    regfile_pkg::rd_req_t    rd1;
    regfile_pkg::rd_result_t rd0_result;
    regfile_pkg::rd_result_t rd1_result;

    // Reference model of the architectural state and the scoreboard
    logic [31:0]       gpr_m [regfile_pkg::NUM_REGS];
    logic [63:0]       mmx_m [regfile_pkg::NUM_REGS];
    logic [31:0]       pend_m;
    regfile_pkg::tag_t tag_m [regfile_pkg::NUM_SECS];

    int errors;
    int checks;
    int tests_run;
    int test_start_errors;

    clock_gen u_clock_gen (.clk(clk), .reset(reset));

    regfile_top u_regfile_top (.clk(clk), .reset(reset), .wr0(wr0), .wr1(wr1), .rsv(rsv),
                               .bcast(bcast), .rd0(rd0), .rd1(rd1),
                               .rd0_result(rd0_result), .rd1_result(rd1_result));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Request builders
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic regfile_pkg::wr_req_t write_req(regfile_pkg::reg_file_e file,
            regfile_pkg::op_size_e size, int addr, logic [63:0] data);
        return '{valid: 1'b1, file: file, size: size,
                 addr: regfile_pkg::reg_addr_t'(addr), data: data};
    endfunction

    function automatic regfile_pkg::rsv_req_t reserve_req(regfile_pkg::reg_file_e file,
            regfile_pkg::op_size_e size, int addr, regfile_pkg::tag_t tag);
        return '{valid: 1'b1, file: file, size: size,
                 addr: regfile_pkg::reg_addr_t'(addr), tag: tag};
    endfunction

    function automatic regfile_pkg::rd_req_t read_req(regfile_pkg::reg_file_e file,
            regfile_pkg::op_size_e size, int addr);
        return '{file: file, size: size, addr: regfile_pkg::reg_addr_t'(addr)};
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Reference model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    function automatic logic [31:0] covered_sections(regfile_pkg::rsv_req_t q);
        logic [31:0] m;
        int          r;
        m = '0;
        r = q.addr;
        if (q.valid && q.file == regfile_pkg::file_mmx) begin
            m[regfile_pkg::NUM_GPR_SECS + r] = 1'b1;
        end else if (q.valid && q.size == regfile_pkg::size8) begin
            m[(r % 4) * 3 + r / 4] = 1'b1;  // Addresses 4 to 7 are the H sections
        end else if (q.valid && q.size == regfile_pkg::size16) begin
            m[r * 3 +: 2] = 2'b11;
        end else if (q.valid && q.size == regfile_pkg::size32) begin
            m[r * 3 +: 3] = 3'b111;
        end
        return m;
    endfunction

    function automatic void apply_write(regfile_pkg::wr_req_t w);
        int r;
        r = w.addr;
        if (w.valid && w.file == regfile_pkg::file_mmx) begin
            mmx_m[r] = w.data;
        end else if (w.valid) begin
            case (w.size)
                regfile_pkg::size8: begin
                    if (r >= 4) gpr_m[r - 4][15:8] = w.data[7:0];
                    else gpr_m[r][7:0] = w.data[7:0];
                end
                regfile_pkg::size16: gpr_m[r][15:0] = w.data[15:0];
                regfile_pkg::size32: gpr_m[r] = w.data[31:0];
                default: ;  // A 64-bit general write touches nothing
            endcase
        end
    endfunction

    // Port 0 goes first so that port 1 overwrites any shared section
    function automatic void apply_model();
        logic [31:0] rmask;
        logic [31:0] hit;
        rmask = covered_sections(rsv);
        for (int s = 0; s < regfile_pkg::NUM_SECS; s++) begin
            hit[s] = bcast.valid && (tag_m[s] == bcast.tag);
        end
        for (int s = 0; s < regfile_pkg::NUM_SECS; s++) begin
            if (rmask[s]) begin
                pend_m[s] = 1'b1;
                tag_m[s]  = rsv.tag;
            end else if (hit[s]) begin
                pend_m[s] = 1'b0;
            end
        end
        apply_write(wr0);
        apply_write(wr1);
    endfunction

    function automatic regfile_pkg::rd_result_t expected_read(regfile_pkg::rd_req_t q);
        regfile_pkg::rd_result_t e;
        int                      r;
        int                      s;
        e = '0;
        r = q.addr;
        if (q.file == regfile_pkg::file_mmx) begin
            e.data    = mmx_m[r];
            e.pending = {2'b00, pend_m[regfile_pkg::NUM_GPR_SECS + r]};
            e.tag_l   = tag_m[regfile_pkg::NUM_GPR_SECS + r];
        end else if (q.size == regfile_pkg::size8) begin
            s         = (r % 4) * 3 + r / 4;
            e.data    = {56'h0, (r >= 4) ? gpr_m[r % 4][15:8] : gpr_m[r][7:0]};
            e.pending = {2'b00, pend_m[s]};
            e.tag_l   = tag_m[s];
        end else if (q.size != regfile_pkg::size64) begin
            e.data    = {48'h0, gpr_m[r][15:0]};
            e.pending = {1'b0, pend_m[r * 3 + 1], pend_m[r * 3]};
            e.tag_h   = tag_m[r * 3 + 1];
            e.tag_l   = tag_m[r * 3];
            if (q.size == regfile_pkg::size32) begin
                e.data[31:16] = gpr_m[r][31:16];
                e.pending[2]  = pend_m[r * 3 + 2];
                e.tag_e       = tag_m[r * 3 + 2];
            end
        end
        return e;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Checking and cycle control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic compare_field(string name, logic [63:0] got, logic [63:0] exp);
        checks++;
        assert (got === exp)
        else begin
            errors++;
            $display("ERROR at %0t: %s is %h, expected %h", $time, name, got, exp);
        end
    endtask

    task automatic compare_port(string name, regfile_pkg::rd_result_t got,
            regfile_pkg::rd_result_t exp);
        compare_field({name, ".data"}, got.data, exp.data);
        compare_field({name, ".pending"}, 64'(got.pending), 64'(exp.pending));
        compare_field({name, ".tag_e"}, 64'(got.tag_e), 64'(exp.tag_e));
        compare_field({name, ".tag_h"}, 64'(got.tag_h), 64'(exp.tag_h));
        compare_field({name, ".tag_l"}, 64'(got.tag_l), 64'(exp.tag_l));
    endtask

    // Inputs are driven 2 ns after an edge and read results are checked mid-cycle
    task automatic run_cycle();
        #10;
        compare_port("rd0_result", rd0_result, expected_read(rd0));
        compare_port("rd1_result", rd1_result, expected_read(rd1));
        apply_model();
        @(posedge clk);
        #2;
        wr0   = '0;
        wr1   = '0;
        rsv   = '0;
        bcast = '0;
    endtask

    task automatic finish_test(string name);
        $display("%-28s %0d errors", name, errors - test_start_errors);
        test_start_errors = errors;
        tests_run++;
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Tests
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic reset_state();
        for (int f = 0; f < 2; f++) begin
            for (int z = 0; z < 4; z++) begin
                for (int a = 0; a < 8; a++) begin
                    rd0 = read_req(regfile_pkg::reg_file_e'(f[0]),
                                   regfile_pkg::op_size_e'(z[1:0]), a);
                    rd1 = read_req(regfile_pkg::reg_file_e'(f[0]),
                                   regfile_pkg::op_size_e'(z[1:0]), 7 - a);
                    run_cycle();
                end
            end
        end
        finish_test("1 reset state");
    endtask

    task automatic sized_writes();
        logic [31:0] v;
        logic [63:0] b;
        for (int r = 0; r < 4; r++) begin
            v   = $urandom;
            b   = {$urandom, $urandom};  // Only the low byte may land
            rd0 = read_req(regfile_pkg::file_gpr, regfile_pkg::size32, r);
            rd1 = read_req(regfile_pkg::file_gpr, regfile_pkg::size8, r + 4);
            wr0 = write_req(regfile_pkg::file_gpr, regfile_pkg::size32, r, {32'h0, v});
            run_cycle();
            wr0 = write_req(regfile_pkg::file_gpr, regfile_pkg::size8, r + 4, b);
            run_cycle();
            compare_field("rd0_result.data", rd0_result.data, {32'h0, v[31:16], b[7:0], v[7:0]});
            rd0 = read_req(regfile_pkg::file_gpr, regfile_pkg::size16, r);
            rd1 = read_req(regfile_pkg::file_gpr, regfile_pkg::size8, r);
            run_cycle();
        end
        finish_test("2 sized writes");
    endtask

    task automatic file_isolation();
        logic [63:0] g;
        logic [63:0] g2;
        logic [63:0] m;
        for (int i = 0; i < regfile_pkg::NUM_REGS; i++) begin
            g   = {$urandom, $urandom};
            g2  = {$urandom, $urandom};
            m   = {$urandom, $urandom};
            rd0 = read_req(regfile_pkg::file_gpr, regfile_pkg::size32, i);
            rd1 = read_req(regfile_pkg::file_mmx, regfile_pkg::size64, i);
            wr0 = write_req(regfile_pkg::file_gpr, regfile_pkg::size32, i, g);
            run_cycle();
            wr1 = write_req(regfile_pkg::file_mmx, regfile_pkg::size64, i, m);
            run_cycle();
            compare_field("rd0_result.data", rd0_result.data, {32'h0, g[31:0]});
            compare_field("rd1_result.data", rd1_result.data, m);
            wr0 = write_req(regfile_pkg::file_gpr, regfile_pkg::size32, i, g2);
            run_cycle();
            compare_field("rd0_result.data", rd0_result.data, {32'h0, g2[31:0]});
            compare_field("rd1_result.data", rd1_result.data, m);
        end
        finish_test("3 gpr and mmx isolation");
    endtask

    task automatic same_cycle_writes();
        logic [63:0] a;
        logic [63:0] b;
        logic [31:0] prev;
        a   = {$urandom, $urandom};
        b   = {$urandom, $urandom};
        wr0 = write_req(regfile_pkg::file_gpr, regfile_pkg::size32, 5, a);
        wr1 = write_req(regfile_pkg::file_gpr, regfile_pkg::size32, 5, b);
        rd0 = read_req(regfile_pkg::file_gpr, regfile_pkg::size32, 5);
        rd1 = read_req(regfile_pkg::file_gpr, regfile_pkg::size32, 2);
        run_cycle();
        compare_field("rd0_result.data", rd0_result.data, {32'h0, b[31:0]});
        prev = gpr_m[2];
        wr0  = write_req(regfile_pkg::file_gpr, regfile_pkg::size8, 2, a);  // Register 2 L
        wr1  = write_req(regfile_pkg::file_gpr, regfile_pkg::size8, 6, b);  // Register 2 H
        run_cycle();
        compare_field("rd1_result.data", rd1_result.data, {32'h0, prev[31:16], b[7:0], a[7:0]});
        wr0 = write_req(regfile_pkg::file_gpr, regfile_pkg::size8, 3, a);
        wr1 = write_req(regfile_pkg::file_gpr, regfile_pkg::size32, 3, b);
        rd0 = read_req(regfile_pkg::file_gpr, regfile_pkg::size32, 3);
        run_cycle();
        compare_field("rd0_result.data", rd0_result.data, {32'h0, b[31:0]});
        wr0 = write_req(regfile_pkg::file_gpr, regfile_pkg::size32, 3, a);
        wr1 = write_req(regfile_pkg::file_gpr, regfile_pkg::size8, 7, b);
        run_cycle();
        compare_field("rd0_result.data", rd0_result.data, {32'h0, a[31:16], b[7:0], a[7:0]});
        wr0 = write_req(regfile_pkg::file_mmx, regfile_pkg::size64, 0, a);
        wr1 = write_req(regfile_pkg::file_mmx, regfile_pkg::size64, 0, b);
        rd1 = read_req(regfile_pkg::file_mmx, regfile_pkg::size64, 0);
        run_cycle();
        compare_field("rd1_result.data", rd1_result.data, b);
        finish_test("4 same-cycle writes");
    endtask

    task automatic reserve_broadcast();
        rsv = reserve_req(regfile_pkg::file_gpr, regfile_pkg::size16, 6, 7'h15);
        rd0 = read_req(regfile_pkg::file_gpr, regfile_pkg::size32, 6);
        rd1 = read_req(regfile_pkg::file_gpr, regfile_pkg::size32, 5);
        run_cycle();
        compare_field("rd0_result.pending", 64'(rd0_result.pending), 64'h3);
        compare_field("rd0_result.tag_h", 64'(rd0_result.tag_h), 64'h15);
        compare_field("rd1_result.pending", 64'(rd1_result.pending), 64'h0);
        bcast = '{valid: 1'b1, tag: 7'h16};  // No section holds this tag
        run_cycle();
        compare_field("rd0_result.pending", 64'(rd0_result.pending), 64'h3);
        bcast = '{valid: 1'b1, tag: 7'h15};
        run_cycle();
        compare_field("rd0_result.pending", 64'(rd0_result.pending), 64'h0);
        compare_field("rd0_result.tag_l", 64'(rd0_result.tag_l), 64'h15);
        rsv = reserve_req(regfile_pkg::file_gpr, regfile_pkg::size8, 1, 7'h22);
        rd0 = read_req(regfile_pkg::file_gpr, regfile_pkg::size8, 1);
        run_cycle();
        rsv   = reserve_req(regfile_pkg::file_gpr, regfile_pkg::size8, 1, 7'h22);
        bcast = '{valid: 1'b1, tag: 7'h22};
        run_cycle();
        compare_field("rd0_result.pending", 64'(rd0_result.pending), 64'h1);
        rsv = reserve_req(regfile_pkg::file_mmx, regfile_pkg::size8, 3, 7'h41);
        rd1 = read_req(regfile_pkg::file_mmx, regfile_pkg::size64, 3);
        run_cycle();
        compare_field("rd1_result.tag_l", 64'(rd1_result.tag_l), 64'h41);
        finish_test("5 reserve and broadcast");
    endtask

    function automatic regfile_pkg::wr_req_t random_write();
        logic [31:0] rnd;
        rnd = $urandom;
        return '{valid: rnd[0], file: regfile_pkg::reg_file_e'(rnd[1]),
                 size: regfile_pkg::op_size_e'(rnd[3:2]), addr: rnd[6:4],
                 data: {$urandom, $urandom}};
    endfunction

    task automatic random_traffic();
        logic [31:0] rnd;
        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            rnd   = $urandom;
            wr0   = random_write();
            wr1   = random_write();
            // Tags come from a small pool so that broadcasts often match
            rsv   = '{valid: rnd[0], file: regfile_pkg::reg_file_e'(rnd[1]),
                      size: regfile_pkg::op_size_e'(rnd[3:2]), addr: rnd[6:4],
                      tag: {4'h0, rnd[9:7]}};
            bcast = '{valid: rnd[10], tag: {4'h0, rnd[13:11]}};
            rd0   = '{file: regfile_pkg::reg_file_e'(rnd[14]),
                      size: regfile_pkg::op_size_e'(rnd[16:15]), addr: rnd[19:17]};
            rd1   = '{file: regfile_pkg::reg_file_e'(rnd[20]),
                      size: regfile_pkg::op_size_e'(rnd[22:21]), addr: rnd[25:23]};
            run_cycle();
        end
        run_cycle();
        finish_test("6 random traffic");
    endtask

    initial begin
        int waited;
        void'($urandom(SEED));
        wr0   = '0;
        wr1   = '0;
        rsv   = '0;
        bcast = '0;
        rd0   = '0;
        rd1   = '0;
        pend_m            = '0;
        errors            = 0;
        checks            = 0;
        tests_run         = 0;
        test_start_errors = 0;
        for (int r = 0; r < regfile_pkg::NUM_REGS; r++) begin
            gpr_m[r] = '0;
            mmx_m[r] = '0;
        end
        for (int s = 0; s < regfile_pkg::NUM_SECS; s++) begin
            tag_m[s] = '0;
        end

        waited = 0;
        do begin
            @(posedge clk);
            waited++;
        end while (reset !== 1'b0 && waited < RESET_TIMEOUT);
        if (reset !== 1'b0) begin
            $display("Reset was still asserted after %0d clock cycles", waited);
            $display("TEST FAIL");
            $finish;
        end else begin
            #2;
            reset_state();
            sized_writes();
            file_isolation();
            same_cycle_writes();
            reserve_broadcast();
            random_traffic();
            $display("%0d tests, %0d checks, %0d errors", tests_run, checks, errors);
            if (errors == 0) begin
                $display("TEST PASS");
            end else begin
                $display("TEST FAIL");
            end
            $finish;
        end
    end

endmodule

// File: src.f
verilog/regfile_pkg.sv
verilog/access_decoder.sv
verilog/reg_storage.sv
verilog/tag_tracker.sv
verilog/read_port.sv
verilog/regfile_top.sv
tests/clock_gen.sv
tests/regfile_tb.sv

// File: run.sh
#!/usr/bin/env bash
# Compiles the register file testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

rm -f sim.log

verilator --binary --timing --assert --timescale 1ns/10ps \
    --top-module regfile_tb -Mdir obj_dir -o regfile_sim -f src.f \
    > build.log 2>&1 \
    && ./obj_dir/regfile_sim > sim.log 2>&1 \
    && grep -qx "TEST PASS" sim.log \
    && echo "Simulation passed" \
    || { echo "Simulation failed, see build.log and sim.log"; exit 1; }
